/* source/dcache_pkg.sv */
package dcache_pkg;

    // geometry: 128 lines of 16 bytes, 32-bit addresses
    localparam int LINE_BYTES = 16;
    localparam int NUM_LINES  = 128;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = 21;
    localparam int LINE_W     = LINE_BYTES * 8;

    // low bits follow funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

    // addr is line aligned, wline only meaningful for writes
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        line_t       wline;
    } mem_req_t;

    typedef struct packed {
        line_t rline;
    } mem_rsp_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    function automatic logic op_is_store(mem_op_e op);
        return op[3];
    endfunction

endpackage

/* source/dcache_line_ram.sv */
`timescale 1ns/1ps

module dcache_line_ram
    import dcache_pkg::*;
#(
    parameter type entry_t = line_t
) (
    input  logic   clk_i,
    input  logic   en_i,
    input  logic   we_i,
    input  index_t addr_i,
    input  entry_t wdata_i,
    output entry_t rdata_o
);

    entry_t mem [NUM_LINES];

    // read-first, output held while disabled
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* source/dcache_lsu_align.sv */
`timescale 1ns/1ps

module dcache_lsu_align
    import dcache_pkg::*;
(
    input  mem_op_e     op_i,
    input  offset_t     offset_i,
    input  line_t       line_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output line_t       line_o
);

    logic [OFFSET_W+2:0] bit_shift;
    line_t               shifted;
    logic [31:0]         word;
    logic [31:0]         st_mask;
    line_t               line_mask;
    line_t               line_data;

    assign bit_shift = {offset_i, 3'b000};

    // addressed bytes moved down to bit 0
    assign shifted = line_i >> bit_shift;
    assign word    = shifted[31:0];

    always_comb begin
        case (op_i)
            OP_LB: begin
                rdata_o = {{24{word[7]}}, word[7:0]};
            end
            OP_LH: begin
                rdata_o = {{16{word[15]}}, word[15:0]};
            end
            OP_LW: begin
                rdata_o = word;
            end
            OP_LBU: begin
                rdata_o = {24'b0, word[7:0]};
            end
            OP_LHU: begin
                rdata_o = {16'b0, word[15:0]};
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

    // byte lanes touched by a store, none for loads
    always_comb begin
        case (op_i)
            OP_SB: begin
                st_mask = 32'h0000_00ff;
            end
            OP_SH: begin
                st_mask = 32'h0000_ffff;
            end
            OP_SW: begin
                st_mask = 32'hffff_ffff;
            end
            default: begin
                st_mask = '0;
            end
        endcase
    end

    assign line_mask = line_t'(st_mask) << bit_shift;
    assign line_data = line_t'(wdata_i) << bit_shift;

    assign line_o = (line_i & ~line_mask) | (line_data & line_mask);

endmodule

/* source/dcache_mem_port.sv */
`timescale 1ns/1ps

module dcache_mem_port
    import dcache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     xfer_start_i,
    input  mem_req_t xfer_req_i,
    output logic     xfer_done_o,
    output mem_rsp_t xfer_rsp_o,
    output logic     mem_req_o,
    output mem_req_t mem_req_data_o,
    input  logic     mem_ack_i,
    input  mem_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_WAIT_LOW
    } port_state_e;

    port_state_e state_q;
    logic        done_q;
    mem_req_t    req_q;
    mem_rsp_t    rsp_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= PORT_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                PORT_IDLE: begin
                    if (xfer_start_i) begin
                        state_q <= PORT_REQ;
                    end
                end
                PORT_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= PORT_WAIT_LOW;
                    end
                end
                default: begin
                    // transfer ends once memory drops its ack
                    if (!mem_ack_i) begin
                        state_q <= PORT_IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == PORT_IDLE && xfer_start_i) begin
            req_q <= xfer_req_i;
        end
        if (state_q == PORT_REQ && mem_ack_i) begin
            rsp_q <= mem_rsp_i;
        end
    end

    assign mem_req_o      = (state_q == PORT_REQ);
    assign mem_req_data_o = req_q;
    assign xfer_done_o    = done_q;
    assign xfer_rsp_o     = rsp_q;

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        cpu_req_i,
    input  cpu_req_t    cpu_req_data_i,
    output logic        cpu_ack_o,
    output cpu_rsp_t    cpu_rsp_o,

    output logic        tag_en_o,
    output logic        tag_we_o,
    output index_t      tag_addr_o,
    output tag_entry_t  tag_wdata_o,
    input  tag_entry_t  tag_rdata_i,

    output logic        data_en_o,
    output logic        data_we_o,
    output line_t       data_wdata_o,
    input  line_t       data_rdata_i,

    output line_t       align_line_o,
    input  logic [31:0] align_rdata_i,
    input  line_t       align_line_i,

    output logic        xfer_start_o,
    output mem_req_t    xfer_req_o,
    input  logic        xfer_done_i,
    input  mem_rsp_t    xfer_rsp_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        ACK
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    cpu_rsp_t             rsp_q;

    logic [TAG_W-1:0]     req_tag;
    index_t               req_index;
    logic                 is_store;
    logic                 hit;
    logic                 ram_rd;
    logic                 ram_wr;
    logic                 fill_done;
    logic                 finish;

    // request is held stable by the CPU until ack
    assign req_tag   = cpu_req_data_i.addr[31 -: TAG_W];
    assign req_index = cpu_req_data_i.addr[OFFSET_W +: INDEX_W];
    assign is_store  = op_is_store(cpu_req_data_i.op);

    assign hit       = valid_q[req_index] && (tag_rdata_i.tag == req_tag);
    assign fill_done = (state_q == REFILL) && xfer_done_i;
    assign ram_rd    = (state_q == IDLE) && cpu_req_i;
    assign ram_wr    = ((state_q == LOOKUP) && hit && is_store) || fill_done;
    assign finish    = ((state_q == LOOKUP) && hit) || fill_done;

    // both arrays share one index
    assign tag_en_o          = ram_rd || ram_wr;
    assign tag_we_o          = ram_wr;
    assign tag_addr_o        = req_index;
    assign tag_wdata_o.tag   = req_tag;

    assign data_en_o         = ram_rd || ram_wr;
    assign data_we_o         = ram_wr;
    assign data_wdata_o      = align_line_i;

    // refill line bypasses the RAM on the fill cycle
    assign align_line_o = (state_q == REFILL) ? xfer_rsp_i.rline : data_rdata_i;

    always_comb begin
        state_d            = state_q;
        xfer_start_o       = 1'b0;
        xfer_req_o.we      = 1'b0;
        xfer_req_o.addr    = {req_tag, req_index, {OFFSET_W{1'b0}}};
        xfer_req_o.wline   = data_rdata_i;

        case (state_q)
            IDLE: begin
                if (cpu_req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = ACK;
                end else if (valid_q[req_index] && dirty_q[req_index]) begin
                    // victim goes out under its old tag
                    xfer_start_o    = 1'b1;
                    xfer_req_o.we   = 1'b1;
                    xfer_req_o.addr = {tag_rdata_i.tag, req_index, {OFFSET_W{1'b0}}};
                    state_d         = WRITEBACK;
                end else begin
                    xfer_start_o = 1'b1;
                    state_d      = REFILL;
                end
            end
            WRITEBACK: begin
                if (xfer_done_i) begin
                    xfer_start_o = 1'b1;
                    state_d      = REFILL;
                end
            end
            REFILL: begin
                if (xfer_done_i) begin
                    state_d = ACK;
                end
            end
            default: begin
                if (!cpu_req_i) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= is_store;
            end else if (ram_wr) begin
                dirty_q[req_index] <= 1'b1;
            end
        end
    end

    // load result, zero for stores
    always_ff @(posedge clk_i) begin
        if (finish) begin
            rsp_q.rdata <= align_rdata_i;
        end
    end

    assign cpu_ack_o = (state_q == ACK);
    assign cpu_rsp_o = rsp_q;

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     cpu_req_i,
    input  cpu_req_t cpu_req_data_i,
    output logic     cpu_ack_o,
    output cpu_rsp_t cpu_rsp_o,

    output logic     mem_req_o,
    output mem_req_t mem_req_data_o,
    input  logic     mem_ack_i,
    input  mem_rsp_t mem_rsp_i
);

    logic        tag_en;
    logic        tag_we;
    index_t      ram_addr;
    tag_entry_t  tag_wdata;
    tag_entry_t  tag_rdata;
    logic        data_en;
    logic        data_we;
    line_t       data_wdata;
    line_t       data_rdata;
    line_t       align_line_in;
    line_t       align_line_out;
    logic [31:0] align_rdata;
    logic        xfer_start;
    mem_req_t    xfer_req;
    logic        xfer_done;
    mem_rsp_t    xfer_rsp;

    dcache_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_req_data_i (cpu_req_data_i),
        .cpu_ack_o      (cpu_ack_o),
        .cpu_rsp_o      (cpu_rsp_o),
        .tag_en_o       (tag_en),
        .tag_we_o       (tag_we),
        .tag_addr_o     (ram_addr),
        .tag_wdata_o    (tag_wdata),
        .tag_rdata_i    (tag_rdata),
        .data_en_o      (data_en),
        .data_we_o      (data_we),
        .data_wdata_o   (data_wdata),
        .data_rdata_i   (data_rdata),
        .align_line_o   (align_line_in),
        .align_rdata_i  (align_rdata),
        .align_line_i   (align_line_out),
        .xfer_start_o   (xfer_start),
        .xfer_req_o     (xfer_req),
        .xfer_done_i    (xfer_done),
        .xfer_rsp_i     (xfer_rsp)
    );

    dcache_line_ram #(
        .entry_t (tag_entry_t)
    ) u_tag_ram (
        .clk_i   (clk_i),
        .en_i    (tag_en),
        .we_i    (tag_we),
        .addr_i  (ram_addr),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    dcache_line_ram #(
        .entry_t (line_t)
    ) u_data_ram (
        .clk_i   (clk_i),
        .en_i    (data_en),
        .we_i    (data_we),
        .addr_i  (ram_addr),
        .wdata_i (data_wdata),
        .rdata_o (data_rdata)
    );

    // op, offset and store data come straight from the held request
    dcache_lsu_align u_align (
        .op_i     (cpu_req_data_i.op),
        .offset_i (cpu_req_data_i.addr[OFFSET_W-1:0]),
        .line_i   (align_line_in),
        .wdata_i  (cpu_req_data_i.wdata),
        .rdata_o  (align_rdata),
        .line_o   (align_line_out)
    );

    dcache_mem_port u_mem_port (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .xfer_start_i   (xfer_start),
        .xfer_req_i     (xfer_req),
        .xfer_done_o    (xfer_done),
        .xfer_rsp_o     (xfer_rsp),
        .mem_req_o      (mem_req_o),
        .mem_req_data_o (mem_req_data_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rsp_i      (mem_rsp_i)
    );

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam logic [31:0] INIT_XOR    = 32'hc0de_8000;
    localparam logic [31:0] LFSR_SEED   = 32'h800b_19de;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam int          ACK_TIMEOUT = 200;
    localparam int          MEM_TIMEOUT = 50;

    logic     clk;
    logic     rst;
    logic     cpu_req;
    cpu_req_t cpu_req_data;
    logic     cpu_ack;
    cpu_rsp_t cpu_rsp;
    logic     mem_req;
    mem_req_t mem_req_data;
    logic     mem_ack;
    mem_rsp_t mem_rsp;

    // main memory lines and the byte image the CPU expects
    line_t      mem_lines [logic [31:0]];
    logic [7:0] shadow    [logic [31:0]];
    mem_req_t   xfer_log  [$];
    logic [31:0] lfsr;

    // expected cache contents, one entry per index
    logic [NUM_LINES-1:0] model_valid;
    logic [NUM_LINES-1:0] model_dirty;
    logic [TAG_W-1:0]     model_tag [NUM_LINES];

    int   check_errors;
    int   timeout_errors;
    logic stalled;

    dcache_top dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .cpu_req_i      (cpu_req),
        .cpu_req_data_i (cpu_req_data),
        .cpu_ack_o      (cpu_ack),
        .cpu_rsp_o      (cpu_rsp),
        .mem_req_o      (mem_req),
        .mem_req_data_o (mem_req_data),
        .mem_ack_i      (mem_ack),
        .mem_rsp_i      (mem_rsp)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    // untouched memory: each word is its byte address xor a constant
    function automatic line_t initial_line(input logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*32 +: 32] = (line_addr + 32'(w * 4)) ^ INIT_XOR;
        end
        return l;
    endfunction

    function automatic line_t read_line(input logic [31:0] line_addr);
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        return initial_line(line_addr);
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] addr);
        line_t l;
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        l = initial_line({addr[31:OFFSET_W], {OFFSET_W{1'b0}}});
        return l[addr[OFFSET_W-1:0]*8 +: 8];
    endfunction

    function automatic line_t shadow_line(input logic [31:0] line_addr);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = shadow_byte(line_addr + 32'(b));
        end
        return l;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic check_value(input string name, input line_t expected, input line_t actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic apply_store(input mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata);
        int nbytes;
        case (op)
            OP_SB: begin
                nbytes = 1;
            end
            OP_SH: begin
                nbytes = 2;
            end
            default: begin
                nbytes = 4;
            end
        endcase
        for (int i = 0; i < nbytes; i++) begin
            shadow[addr + 32'(i)] = wdata[i*8 +: 8];
        end
    endtask

    task automatic run_access(input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] expected);
        index_t           idx;
        logic [TAG_W-1:0] tag;
        logic             store;
        logic             hit;
        logic             wb;
        logic [31:0]      victim_addr;
        line_t            victim_line;
        mem_req_t         first;
        mem_req_t         last;
        int               cycles;
        idx         = addr[OFFSET_W +: INDEX_W];
        tag         = addr[31 -: TAG_W];
        store       = op inside {OP_SB, OP_SH, OP_SW};
        hit         = model_valid[idx] && (model_tag[idx] == tag);
        wb          = !hit && model_valid[idx] && model_dirty[idx];
        victim_addr = {model_tag[idx], idx, {OFFSET_W{1'b0}}};
        victim_line = shadow_line(victim_addr);

        xfer_log.delete();
        cpu_req_data.op    = op;
        cpu_req_data.addr  = addr;
        cpu_req_data.wdata = wdata;
        cpu_req            = 1'b1;

        cycles = 0;
        while (!cpu_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!cpu_ack) begin
            timeout_errors++;
            stalled = 1'b1;
            $display("cache never acknowledged the access to address %h", addr);
            return;
        end

        check_value("cpu_rsp_o.rdata", line_t'(expected), line_t'(cpu_rsp.rdata));
        if (hit) begin
            check_value("cpu_ack_o hit latency", line_t'(2), line_t'(cycles));
            check_value("memory transfers on hit", line_t'(0), line_t'(xfer_log.size()));
        end else begin
            check_value("memory transfers on miss", line_t'(wb ? 2 : 1),
                        line_t'(xfer_log.size()));
            if (xfer_log.size() == (wb ? 2 : 1)) begin
                first = xfer_log[0];
                last  = xfer_log[xfer_log.size() - 1];
                if (wb) begin
                    check_value("mem_req_data_o.we write-back", line_t'(1), line_t'(first.we));
                    check_value("mem_req_data_o.addr write-back", line_t'(victim_addr),
                                line_t'(first.addr));
                    check_value("mem_req_data_o.wline", victim_line, first.wline);
                end
                check_value("mem_req_data_o.we refill", line_t'(0), line_t'(last.we));
                check_value("mem_req_data_o.addr refill",
                            line_t'({addr[31:OFFSET_W], {OFFSET_W{1'b0}}}),
                            line_t'(last.addr));
            end
        end

        if (store) begin
            apply_store(op, addr, wdata);
        end
        model_dirty[idx] = hit ? (model_dirty[idx] || store) : store;
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;

        cpu_req = 1'b0;
        cycles  = 0;
        while (cpu_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (cpu_ack) begin
            timeout_errors++;
            stalled = 1'b1;
            $display("cpu_ack_o stayed high after the request for %h was dropped", addr);
            return;
        end
        check_value("cpu_ack_o fall latency", line_t'(1), line_t'(cycles));
    endtask

    // answers each memory request after a random number of cycles
    initial begin : memory_model
        int         wait_n;
        logic [2:0] delay;
        lfsr    = LFSR_SEED;
        mem_ack = 1'b0;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !stalled) begin
                delay = '0;
                for (int b = 0; b < 3; b++) begin
                    lfsr  = lfsr_next(lfsr);
                    delay = {delay[1:0], lfsr[0]};
                end
                for (int d = 0; d < int'(delay); d++) begin
                    @(posedge clk);
                    #1;
                end
                xfer_log.push_back(mem_req_data);
                if (mem_req_data.we) begin
                    mem_lines[mem_req_data.addr] = mem_req_data.wline;
                end else begin
                    mem_rsp.rline = read_line(mem_req_data.addr);
                end
                mem_ack = 1'b1;
                wait_n  = 0;
                while (mem_req && wait_n < MEM_TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    wait_n++;
                end
                if (mem_req) begin
                    timeout_errors++;
                    stalled = 1'b1;
                    $display("mem_req_o did not fall after the memory acknowledge");
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          code;
        int          count;
        string       text;
        logic [3:0]  op_raw;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        check_errors   = 0;
        timeout_errors = 0;
        stalled        = 1'b0;
        count          = 0;
        rst            = 1'b0;
        cpu_req        = 1'b0;
        cpu_req_data   = '0;
        model_valid    = '0;
        model_dirty    = '0;
        model_tag      = '{default: '0};

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        check_value("cpu_ack_o after reset", line_t'(0), line_t'(cpu_ack));
        check_value("mem_req_o after reset", line_t'(0), line_t'(mem_req));

        fd = $fopen("tb/dcache_vectors.txt", "r");
        if (fd == 0) begin
            check_errors++;
            $display("could not open the vector file tb/dcache_vectors.txt");
        end
        // columns: op, address, store data, expected load data
        while (fd != 0 && !stalled && !$feof(fd)) begin
            code = $fgets(text, fd);
            if (code > 0 && text.len() > 1 && text.getc(0) != "#") begin
                if ($sscanf(text, "%h %h %h %h", op_raw, addr, wdata, expected) == 4) begin
                    run_access(mem_op_e'(op_raw), addr, wdata, expected);
                    count++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (count == 0) begin
            check_errors++;
            $display("no accesses were read from the vector file");
        end

        $display("errors: %0d check, %0d timeout, %0d accesses run",
                 check_errors, timeout_errors, count);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/dcache_vectors.txt */
# op (hex, 0 lb 1 lh 2 lw 4 lbu 5 lhu 8 sb 9 sh a sw), address, store data, expected rdata
# untouched memory words read as address xor c0de8000, stores expect rdata 0
2 00000100 00000000 c0de8100
0 00000101 00000000 ffffff81
4 00000101 00000000 00000081
1 00000102 00000000 ffffc0de
5 00000102 00000000 0000c0de
0 00000104 00000000 00000004
1 00000108 00000000 ffff8108
5 0000010c 00000000 0000810c
2 0000010c 00000000 c0de810c
8 00000105 123456a5 00000000
2 00000104 00000000 c0dea504
9 0000010a 7777beef 00000000
2 00000108 00000000 beef8108
a 0000010c 12345678 00000000
0 0000010f 00000000 00000012
2 00000100 00000000 c0de8100
# same index, new tag: dirty victim written back first
2 00000900 00000000 c0de8900
0 00000907 00000000 ffffffc0
# clean victim, reload shows the written-back bytes
2 00000104 00000000 c0dea504
2 00000108 00000000 beef8108
2 0000010c 00000000 12345678
a 00000100 deadbeef 00000000
4 00001103 00000000 000000c0
# store miss allocates and dirties the line
9 00002206 00005a5a 00000000
2 00002204 00000000 5a5aa204
1 00002200 00000000 ffffa200
5 00002a02 00000000 0000c0de
2 00002204 00000000 5a5aa204
a 00000ff0 00c0ffee 00000000
2 00000ff0 00000000 00c0ffee
0 00000ff4 00000000 fffffff4
2 000007f0 00000000 c0de87f0
2 00000ff0 00000000 00c0ffee
4 00000ff1 00000000 000000ff
0 00000ff2 00000000 ffffffc0

/* flist.f */
source/dcache_pkg.sv
source/dcache_line_ram.sv
source/dcache_lsu_align.sv
source/dcache_mem_port.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
